// File: hdl/bht_pkg.sv
package bht_pkg;

    localparam int bht_entries  = 8;
    localparam int bp_reg_width = 16;

    // bit 1 set means predicted taken
    typedef enum logic [1:0] {
        strong_not   = 2'b00,
        weak_not     = 2'b01,
        weak_taken   = 2'b10,
        strong_taken = 2'b11
    } bht_state_e;

    // travels down the pipe with the branch
    typedef struct packed {
        core_addr_pkg::im_addr_t pc_4;
        core_addr_pkg::im_addr_t guess_pc;
        bht_state_e              guess_state;
    } bht_pred_t;

    typedef struct packed {
        logic                    valid;
        core_addr_pkg::im_addr_t pc_4;
        core_addr_pkg::im_addr_t target;
        logic                    taken;
        bht_pred_t               pred;   // as captured at fetch
    } bht_resolve_t;

    typedef enum logic [1:0] {
        reg_ctrl        = 2'd0,
        reg_branches    = 2'd1,
        reg_mispredicts = 2'd2
    } bp_reg_addr_e;

endpackage

// File: hdl/bht_table.sv
`timescale 1ns/1ps

module bht_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pred_en,
    input  core_addr_pkg::im_addr_t pc_4,
    input  logic                    update_en,
    input  core_addr_pkg::im_addr_t update_pc_4,
    input  core_addr_pkg::im_addr_t update_target,
    input  bht_pkg::bht_state_e     new_state,
    output bht_pkg::bht_pred_t      pred
);
    import core_addr_pkg::*;
    import bht_pkg::*;

    typedef struct packed {
        bht_state_e state;
        im_addr_t   target;
    } entry_t;

    localparam int entry_bits = $bits(entry_t);

    logic [bht_entries-1:0] valid_q;
    logic [bht_entries-1:0] lru_q [bht_entries];  // all-ones row is the victim
    im_addr_t               tag_q [bht_entries];
    entry_t                 data_q [bht_entries];

    logic [bht_entries-1:0] look_sel;
    logic [bht_entries-1:0] upd_sel;
    logic [bht_entries-1:0] victim;
    logic [bht_entries-1:0] wr_mask;
    logic [entry_bits-1:0]  tree [1:2*bht_entries-1];  // leaves at 8..15
    entry_t                 hit_entry;

    // tag match for both ports
    always_comb begin
        for (int i = 0; i < bht_entries; i++) begin
            look_sel[i] = valid_q[i] && (tag_q[i] == pc_4);
            upd_sel[i]  = valid_q[i] && (tag_q[i] == update_pc_4);
            victim[i]   = &lru_q[i];
        end
    end

    // merge the hit entry, at most one leaf is nonzero
    always_comb begin
        for (int i = 0; i < bht_entries; i++) begin
            tree[bht_entries+i] = look_sel[i] ? data_q[i] : '0;
        end
        for (int n = bht_entries - 1; n >= 1; n--) begin
            tree[n] = tree[2*n] | tree[2*n+1];
        end
    end

    assign hit_entry = entry_t'(tree[1]);

    always_comb begin
        pred.pc_4        = pc_4;
        pred.guess_pc    = pc_4;
        pred.guess_state = strong_not;   // miss reads as zero anyway
        if (pred_en) begin
            pred.guess_state = hit_entry.state;
            if (hit_entry.state[1]) begin
                pred.guess_pc = hit_entry.target;
            end
        end
    end

    assign wr_mask = (|upd_sel) ? upd_sel : victim;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            for (int i = 0; i < bht_entries; i++) begin
                for (int j = 0; j < bht_entries; j++) begin
                    lru_q[i][j] <= (i <= j);
                end
            end
        end else if (update_en) begin
            valid_q <= valid_q | wr_mask;
            for (int n = 0; n < bht_entries; n++) begin
                // used row keeps only its own bit, others gain its column
                lru_q[n] <= wr_mask[n] ? wr_mask : (lru_q[n] | wr_mask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_en) begin
            for (int i = 0; i < bht_entries; i++) begin
                if (wr_mask[i]) begin
                    tag_q[i]         <= update_pc_4;
                    data_q[i].state  <= new_state;
                    data_q[i].target <= update_target;
                end
            end
        end
    end

endmodule

// File: hdl/bp_ctrl_regs.sv
`timescale 1ns/1ps

module bp_ctrl_regs (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               reg_wr,
    input  bht_pkg::bp_reg_addr_e              reg_addr,
    input  logic [bht_pkg::bp_reg_width-1:0]   reg_wdata,
    output logic [bht_pkg::bp_reg_width-1:0]   reg_rdata,
    input  logic                               branch_done,
    input  logic                               mispredict,
    output logic                               pred_en
);
    import bht_pkg::*;

    // index 0 counts branches, 1 counts mispredicts
    logic [bp_reg_width-1:0] cnt_q [2];
    logic [1:0]              cnt_inc;
    logic [1:0]              cnt_clr;

    assign cnt_inc    = {mispredict, branch_done};
    assign cnt_clr[0] = reg_wr && (reg_addr == reg_branches);
    assign cnt_clr[1] = reg_wr && (reg_addr == reg_mispredicts);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_en <= 1'b1;
        end else if (reg_wr && (reg_addr == reg_ctrl)) begin
            pred_en <= reg_wdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;          // clear wins over a pulse
                end else if (cnt_inc[i] && !(&cnt_q[i])) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;   // sticks at max
                end
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            reg_ctrl:        reg_rdata[0] = pred_en;
            reg_branches:    reg_rdata    = cnt_q[0];
            reg_mispredicts: reg_rdata    = cnt_q[1];
            default:         reg_rdata    = '0;
        endcase
    end

endmodule

// File: hdl/bp_top.sv
`timescale 1ns/1ps

module bp_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             fetch_en,
    input  bht_pkg::bht_resolve_t            resolve,
    input  logic                             reg_wr,
    input  bht_pkg::bp_reg_addr_e            reg_addr,
    input  logic [bht_pkg::bp_reg_width-1:0] reg_wdata,
    output core_addr_pkg::im_addr_t          fetch_pc,
    output bht_pkg::bht_pred_t               fetch_pred,
    output logic [bht_pkg::bp_reg_width-1:0] reg_rdata
);
    import core_addr_pkg::*;
    import bht_pkg::*;

    im_addr_t   pc_4;
    im_addr_t   redirect_pc;
    bht_state_e new_state;
    logic       update_en;
    logic       redirect;
    logic       branch_done;
    logic       mispredict;
    logic       pred_en;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .guess_pc    (fetch_pred.guess_pc),   // predicted next fetch
        .fetch_pc    (fetch_pc),
        .pc_4        (pc_4)
    );

    bht_table bht_table_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .pred_en       (pred_en),
        .pc_4          (pc_4),
        .update_en     (update_en),
        .update_pc_4   (resolve.pc_4),
        .update_target (resolve.target),
        .new_state     (new_state),
        .pred          (fetch_pred)
    );

    branch_resolve branch_resolve_inst (
        .resolve     (resolve),
        .pred_en     (pred_en),
        .update_en   (update_en),
        .new_state   (new_state),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .branch_done (branch_done),
        .mispredict  (mispredict)
    );

    bp_ctrl_regs bp_ctrl_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .branch_done (branch_done),
        .mispredict  (mispredict),
        .pred_en     (pred_en)
    );

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  bht_pkg::bht_resolve_t   resolve,
    input  logic                    pred_en,
    output logic                    update_en,
    output bht_pkg::bht_state_e     new_state,
    output logic                    redirect,
    output core_addr_pkg::im_addr_t redirect_pc,
    output logic                    branch_done,
    output logic                    mispredict
);
    import core_addr_pkg::*;
    import bht_pkg::*;

    im_addr_t correct_pc;

    // saturating 2-bit counter step
    always_comb begin
        case (resolve.pred.guess_state)
            strong_not:   new_state = resolve.taken ? weak_not : strong_not;
            weak_not:     new_state = resolve.taken ? weak_taken : strong_not;
            weak_taken:   new_state = resolve.taken ? strong_taken : weak_not;
            strong_taken: new_state = resolve.taken ? strong_taken : weak_taken;
            default:      new_state = strong_not;
        endcase
    end

    assign correct_pc = resolve.taken ? resolve.target : resolve.pc_4;

    assign mispredict  = resolve.valid && (correct_pc != resolve.pred.guess_pc);
    assign redirect    = mispredict;
    assign redirect_pc = correct_pc;

    assign update_en   = resolve.valid && pred_en;  // table frozen while disabled
    assign branch_done = resolve.valid;

endmodule

// File: hdl/core_addr_pkg.sv
package core_addr_pkg;

    // word addresses, so pc_4 is pc + 1
    localparam int im_addr_bits = 10;

    typedef logic [im_addr_bits-1:0] im_addr_t;

    localparam im_addr_t reset_pc = '0;

endpackage

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_en,
    input  logic                    redirect,
    input  core_addr_pkg::im_addr_t redirect_pc,
    input  core_addr_pkg::im_addr_t guess_pc,
    output core_addr_pkg::im_addr_t fetch_pc,
    output core_addr_pkg::im_addr_t pc_4
);
    import core_addr_pkg::*;

    im_addr_t next_pc;

    // redirect from execute beats the prediction
    always_comb begin
        next_pc = fetch_pc;
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (fetch_en) begin
            next_pc = guess_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= reset_pc;
        end else begin
            fetch_pc <= next_pc;
        end
    end

    assign pc_4 = fetch_pc + im_addr_t'(1);  // next word

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bp_tb -f vlog.f -o bp_sim

./obj_dir/bp_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/bp_props.sv
`timescale 1ns/1ps

module bp_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    redirect,
    input core_addr_pkg::im_addr_t redirect_pc,
    input core_addr_pkg::im_addr_t fetch_pc,
    input logic                    update_en,
    input logic                    pred_en,
    input bht_pkg::bht_pred_t      fetch_pred,
    input bht_pkg::bht_resolve_t   resolve
);
    int unsigned fail_count = 0;

    // fetch lands on the corrected pc one edge later
    redirect_lands: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> fetch_pc == $past(redirect_pc))
        else begin
            fail_count++;
            $error("fetch_pc did not load redirect_pc after a redirect");
        end

    update_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        update_en |-> pred_en)
        else begin
            fail_count++;
            $error("table update while the predictor is disabled");
        end

    not_taken_falls_through: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_pred.guess_state[1] |-> fetch_pred.guess_pc == fetch_pred.pc_4)
        else begin
            fail_count++;
            $error("not-taken prediction does not point at pc_4");
        end

    update_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        update_en |-> resolve.valid)
        else begin
            fail_count++;
            $error("table update without a valid resolve");
        end

endmodule

bind bp_top bp_props bp_props_inst (.*);

// File: tests/bp_tb.sv
`timescale 1ns/1ps

module bp_tb;
    import core_addr_pkg::*;
    import bht_pkg::*;

    typedef struct packed {
        bht_resolve_t            res;        // pred filled in by the model
        logic                    fetch_en;
        logic                    reg_wr;
        bp_reg_addr_e            reg_addr;   // also the register read back
        logic [bp_reg_width-1:0] reg_wdata;
        im_addr_t                exp_pc;
        bht_pred_t               exp_pred;
        logic [bp_reg_width-1:0] exp_rdata;
    } row_t;

    localparam int cnt_max = (1 << bp_reg_width) - 1;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    fetch_en;
    bht_resolve_t            resolve;
    logic                    reg_wr;
    bp_reg_addr_e            reg_addr;
    logic [bp_reg_width-1:0] reg_wdata;
    im_addr_t                fetch_pc;
    bht_pred_t               fetch_pred;
    logic [bp_reg_width-1:0] reg_rdata;

    row_t        rows [$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 10000;
    int unsigned seed;

    // reference model of the predictor
    logic [bht_entries-1:0] m_valid = '0;
    im_addr_t               m_tag [bht_entries];
    im_addr_t               m_target [bht_entries];
    bht_state_e             m_state [bht_entries];
    int                     m_order [$];         // least recently used first
    im_addr_t               m_pc = reset_pc;
    logic                   m_en = 1'b1;
    int                     m_cnt [2] = '{0, 0};  // branches, mispredicts

    bp_top bp_top_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic bht_pred_t lookup(im_addr_t pc4);
        bht_pred_t p;
        p.pc_4        = pc4;
        p.guess_pc    = pc4;
        p.guess_state = strong_not;
        for (int i = 0; i < bht_entries; i++) begin
            if (m_en && m_valid[i] && m_tag[i] == pc4) begin
                p.guess_state = m_state[i];
                if (m_state[i][1]) p.guess_pc = m_target[i];
            end
        end
        return p;
    endfunction

    // counter as a level from 0 to 3
    function automatic bht_state_e next_state(bht_state_e s, logic taken);
        int level;
        level = int'(s) + (taken ? 1 : -1);
        if (level > 3) level = 3;
        if (level < 0) level = 0;
        return bht_state_e'(level);
    endfunction

    task automatic add_row(input int v, input int pc4, input int tgt, input int tk,
                           input int fe, input int wr, input int addr, input int wd);
        row_t      r;
        bht_pred_t fetch_look;
        im_addr_t  correct;
        logic      mp;
        int        slot;
        int        idx;
        r = '0;
        r.res.valid  = (v != 0);
        r.res.pc_4   = im_addr_t'(pc4);
        r.res.target = im_addr_t'(tgt);
        r.res.taken  = (tk != 0);
        r.res.pred   = lookup(r.res.pc_4);   // what fetch saw for this branch
        r.fetch_en   = (fe != 0);
        r.reg_wr     = (wr != 0);
        r.reg_addr   = bp_reg_addr_e'(addr);
        r.reg_wdata  = bp_reg_width'(wd);
        correct    = r.res.taken ? r.res.target : r.res.pc_4;
        mp         = r.res.valid && (correct != r.res.pred.guess_pc);
        fetch_look = lookup(im_addr_t'(m_pc + 1));
        if (r.res.valid && m_en) begin
            slot = m_order[0];
            for (int i = 0; i < bht_entries; i++) begin
                if (m_valid[i] && m_tag[i] == r.res.pc_4) slot = i;
            end
            m_valid[slot]  = 1'b1;
            m_tag[slot]    = r.res.pc_4;
            m_target[slot] = r.res.target;
            m_state[slot]  = next_state(r.res.pred.guess_state, r.res.taken);
            for (int k = 0; k < m_order.size(); k++) begin
                if (m_order[k] == slot) idx = k;
            end
            m_order.delete(idx);
            m_order.push_back(slot);
        end
        if (mp) m_pc = correct;
        else if (r.fetch_en) m_pc = fetch_look.guess_pc;
        if (r.reg_wr && r.reg_addr == reg_branches) m_cnt[0] = 0;
        else if (r.res.valid && m_cnt[0] < cnt_max) m_cnt[0]++;
        if (r.reg_wr && r.reg_addr == reg_mispredicts) m_cnt[1] = 0;
        else if (mp && m_cnt[1] < cnt_max) m_cnt[1]++;
        if (r.reg_wr && r.reg_addr == reg_ctrl) m_en = r.reg_wdata[0];
        r.exp_pc   = m_pc;
        r.exp_pred = lookup(im_addr_t'(m_pc + 1));
        case (r.reg_addr)
            reg_ctrl:        r.exp_rdata = bp_reg_width'(m_en);
            reg_branches:    r.exp_rdata = bp_reg_width'(m_cnt[0]);
            reg_mispredicts: r.exp_rdata = bp_reg_width'(m_cnt[1]);
            default:         r.exp_rdata = '0;
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        int wr;
        add_row(0, 0, 0, 0, 0, 0, reg_ctrl, 0);
        repeat (3) add_row(0, 0, 0, 0, 1, 0, reg_branches, 0);
        // branch at 8 loops to itself, climb to strong_taken
        repeat (4) add_row(1, 9, 8, 1, 0, 0, reg_mispredicts, 0);
        add_row(1, 9, 8, 0, 0, 0, reg_branches, 0);
        add_row(1, 20, 8, 1, 0, 0, reg_mispredicts, 0);   // back to 8
        add_row(1, 9, 8, 0, 0, 0, reg_branches, 0);
        add_row(1, 21, 8, 1, 0, 0, reg_mispredicts, 0);
        repeat (2) add_row(1, 9, 8, 0, 0, 0, reg_mispredicts, 0);
        add_row(0, 0, 0, 0, 1, 0, reg_ctrl, 0);
        for (int n = 0; n < 9; n++) add_row(1, 100 + n, 99, 1, 0, 0, reg_branches, 0);
        add_row(1, 101, 99, 1, 0, 0, reg_mispredicts, 0);  // refresh one entry
        repeat (3) add_row(0, 0, 0, 0, 1, 0, reg_ctrl, 0);
        add_row(0, 0, 0, 0, 0, 1, reg_ctrl, 0);
        repeat (2) add_row(0, 0, 0, 0, 1, 0, reg_ctrl, 0);
        add_row(1, 101, 99, 0, 0, 0, reg_branches, 0);
        add_row(1, 9, 8, 1, 0, 0, reg_mispredicts, 0);
        add_row(1, 9, 8, 1, 0, 1, reg_branches, 0);
        add_row(0, 0, 0, 0, 0, 1, reg_mispredicts, 0);
        add_row(0, 0, 0, 0, 0, 1, reg_ctrl, 1);
        add_row(1, 300, 100, 1, 0, 0, reg_ctrl, 0);
        add_row(0, 0, 0, 0, 1, 0, reg_branches, 0);
        for (int n = 0; n < 40; n++) begin
            wr = (($urandom % 8) == 0);
            add_row($urandom % 2, 16 + $urandom % 12, $urandom % (1 << im_addr_bits),
                    $urandom % 2, $urandom % 2, wr, $urandom % 3, $urandom % 2);
        end
    endtask

    task automatic check_row(input int i);
        checks += 3;
        if (fetch_pc !== rows[i].exp_pc) begin
            errors++;
            $display("FAILED @%0t: row %0d fetch_pc %0d, expected %0d",
                     $time, i, fetch_pc, rows[i].exp_pc);
        end
        if (fetch_pred !== rows[i].exp_pred) begin
            errors++;
            $display("FAILED @%0t: row %0d pred pc_4/guess/state %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, i, fetch_pred.pc_4, fetch_pred.guess_pc, fetch_pred.guess_state,
                     rows[i].exp_pred.pc_4, rows[i].exp_pred.guess_pc,
                     rows[i].exp_pred.guess_state);
        end
        if (reg_rdata !== rows[i].exp_rdata) begin
            errors++;
            $display("FAILED @%0t: row %0d reg %0d reads %0d, expected %0d",
                     $time, i, rows[i].reg_addr, reg_rdata, rows[i].exp_rdata);
        end
    endtask

    initial begin
        seed      = $urandom(32'h27ecf8c2);
        rst_n     = 1'b0;
        fetch_en  = 1'b0;
        resolve   = '0;
        reg_wr    = 1'b0;
        reg_addr  = reg_ctrl;
        reg_wdata = '0;
        for (int i = 0; i < bht_entries; i++) m_order.push_back(i);  // entry 0 oldest
        build_table();
        cycle_limit = 2 * rows.size() + 20;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            resolve   = rows[i].res;
            fetch_en  = rows[i].fetch_en;
            reg_wr    = rows[i].reg_wr;
            reg_addr  = rows[i].reg_addr;
            reg_wdata = rows[i].reg_wdata;
            @(posedge clk);
            #1;
            check_row(i);
        end
        errors += bp_top_inst.bp_props_inst.fail_count;
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/core_addr_pkg.sv
hdl/bht_pkg.sv
hdl/bht_table.sv
hdl/fetch_pc_gen.sv
hdl/branch_resolve.sv
hdl/bp_ctrl_regs.sv
hdl/bp_top.sv
tests/bp_props.sv
tests/bp_tb.sv
